// ==== hw/irq_cfg.svh ====
/*
  Build-time settings for the machine-mode interrupt unit.
  TRAP_CREDITS must fit credit_t (2 bits), so 1 to 3 credits are possible.
  IRQ_MASK must keep the reserved lines 15:12, 10:8, 6:4 and 2:0 at zero.
*/
`ifndef IRQ_CFG_SVH
`define IRQ_CFG_SVH

//////////////////////////////
// Implemented interrupt lines
//////////////////////////////
`define IRQ_MASK      32'hFFFF_0888  // Custom 31:16, MEI, MTI, MSI
`define IRQ_MEI_BIT   11             // Machine external
`define IRQ_MSI_BIT   3              // Machine software
`define IRQ_MTI_BIT   7              // Machine timer

//////////////////////////////
// CSR addresses
//////////////////////////////
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MCAUSE    12'h342
`define CSR_MIP       12'h344

// Credits granted by the core after reset
`define TRAP_CREDITS  2

`endif

// ==== hw/irq_pkg.sv ====
/*
  Shared types of the interrupt unit.
  Only machine and user privilege are meaningful here.
  Widths are fixed and follow the RV32 CSR layout.
*/
package irq_pkg;

  //////////////////////////////
  // Vector and id types
  //////////////////////////////
  typedef logic [31:0] irq_vec_t;   // One bit per interrupt line
  typedef logic [4:0]  irq_id_t;    // Encoded line number

  //////////////////////////////
  // CSR types
  //////////////////////////////
  typedef logic [11:0] csr_addr_t;  // CSR address
  typedef logic [31:0] csr_data_t;  // CSR read and write data
  typedef logic [1:0]  priv_lvl_t;  // 3 is machine, 0 is user

  // Trap credit count, up to 3
  typedef logic [1:0]  credit_t;

  // Trap sequencer states
  typedef enum logic {
    TRAP_IDLE,   // Waiting for a request and a credit
    TRAP_ISSUE   // trap_valid_o high for one cycle
  } trap_state_t;

endpackage

// ==== hw/irq_ctrl_if.sv ====
/*
  Internal bundle between interrupt controller, CSR block and trap sequencer.
  trap_cause is valid in the same cycle as trap_take.
  priv is driven for observation only, no block inside the unit reads it.
*/
`timescale 1ns/1ps

interface irq_ctrl_if import irq_pkg::*; ();

  logic       irq_req;     // Qualified interrupt pending
  irq_id_t    irq_id;      // Highest priority pending line
  logic       irq_wu;      // Wake-up, unregistered
  irq_vec_t   mie;         // MIE CSR
  logic       m_ie;        // Global enable
  priv_lvl_t  priv;        // Current privilege
  irq_vec_t   mip;         // Registered and masked lines
  logic       trap_take;   // Trap entry this cycle
  csr_data_t  trap_cause;  // Cause written to mcause on entry

  // Interrupt controller side
  modport ctrl (output irq_req, irq_id, irq_wu, mip,
                input  mie, m_ie);

  // CSR block side
  modport csr  (output mie, m_ie, priv,
                input  mip, trap_take, trap_cause);

  // Trap sequencer side
  modport seq  (output trap_take, trap_cause,
                input  irq_req, irq_id);

endinterface

// ==== hw/irq_int_controller.sv ====
/*
  Level interrupt lines are registered once before any trap logic sees them.
  Lines outside IRQ_MASK read as zero in mip and never request a trap.
  Wake-up is combinational from the pins, so it works with a stopped clock.
*/
`timescale 1ns/1ps
`include "irq_cfg.svh"

module irq_int_controller import irq_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  irq_vec_t irq_i,    // Level interrupt inputs
  irq_ctrl_if.ctrl irq_if    // To CSR block and sequencer
);

  irq_vec_t irq_q;           // Registered lines
  irq_vec_t irq_local_qual;  // Pending and enabled in mie
  irq_id_t  irq_id;          // Encoder result

  //////////////////////////////
  // Input register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_i & `IRQ_MASK;  // Drop reserved lines
    end
  end

  assign irq_if.mip = irq_q;  // Read-only mip view

  // Local qualification by mie
  assign irq_local_qual = irq_q & irq_if.mie;

  // Request only when globally enabled
  assign irq_if.irq_req = (|irq_local_qual) && irq_if.m_ie;

  // Wake-up from the raw pins
  assign irq_if.irq_wu = |(irq_i & irq_if.mie);

  //////////////////////////////
  // Priority encoder
  //////////////////////////////
  // Later assignments win, so the lowest priority is set first
  always_comb begin
    irq_id = irq_id_t'(`IRQ_MTI_BIT);  // Timer, lowest
    if (irq_local_qual[`IRQ_MSI_BIT]) begin
      irq_id = irq_id_t'(`IRQ_MSI_BIT);  // Software over timer
    end
    if (irq_local_qual[`IRQ_MEI_BIT]) begin
      irq_id = irq_id_t'(`IRQ_MEI_BIT);  // External over software
    end
    // Custom lines, highest number wins
    for (int i = 16; i < 32; i++) begin
      if (irq_local_qual[i]) begin
        irq_id = irq_id_t'(i);
      end
    end
  end

  // Only meaningful while irq_req is high
  assign irq_if.irq_id = irq_id;

endmodule

// ==== hw/irq_csr_regs.sv ====
/*
  Machine-mode CSRs of the interrupt unit: mstatus, mie, mip and mcause.
  Only MIE, MPIE and MPP exist in mstatus, other bits read as zero.
  Same-cycle priority is trap entry, then mret, then a CSR write.
  Reads are combinational, writes take effect at the clock edge.
*/
`timescale 1ns/1ps
`include "irq_cfg.svh"

module irq_csr_regs import irq_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      csr_we_i,     // Write strobe
  input  csr_addr_t csr_addr_i,   // Read and write address
  input  csr_data_t csr_wdata_i,  // Write data
  output csr_data_t csr_rdata_o,  // Read data
  input  logic      mret_i,       // Return from trap
  irq_ctrl_if.csr   irq_if        // From controller and sequencer
);

  localparam priv_lvl_t priv_machine = 2'b11;
  localparam priv_lvl_t priv_user    = 2'b00;
  localparam int        mstatus_mie  = 3;
  localparam int        mstatus_mpie = 7;

  irq_vec_t  mie_q;           // Interrupt enables
  logic      mstatus_mie_q;   // Global machine enable
  logic      mstatus_mpie_q;  // Enable before trap
  priv_lvl_t mstatus_mpp_q;   // Privilege before trap
  csr_data_t mcause_q;        // Last trap cause
  priv_lvl_t priv_q;          // Current privilege
  csr_data_t mstatus_rd;      // Assembled mstatus view

  //////////////////////////////
  // State update
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q          <= '0;
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mstatus_mpp_q  <= priv_user;
      mcause_q       <= '0;
      priv_q         <= priv_machine;  // Hart starts in machine mode
    end else if (irq_if.trap_take) begin
      // Trap entry
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;          // Blocks a second trap
      mstatus_mpp_q  <= priv_q;
      priv_q         <= priv_machine;
      mcause_q       <= irq_if.trap_cause;
    end else if (mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
      priv_q         <= mstatus_mpp_q;
      mstatus_mpp_q  <= priv_user;     // Least privileged mode
    end else if (csr_we_i) begin
      case (csr_addr_i)
        `CSR_MSTATUS: begin
          mstatus_mie_q  <= csr_wdata_i[mstatus_mie];
          mstatus_mpie_q <= csr_wdata_i[mstatus_mpie];
          mstatus_mpp_q  <= csr_wdata_i[12:11];
        end
        `CSR_MIE:    mie_q    <= csr_wdata_i & `IRQ_MASK;  // Masked bits only
        `CSR_MCAUSE: mcause_q <= csr_wdata_i;
        default: ;  // mip and unknown addresses ignore writes
      endcase
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////
  always_comb begin
    mstatus_rd               = '0;
    mstatus_rd[mstatus_mie]  = mstatus_mie_q;
    mstatus_rd[mstatus_mpie] = mstatus_mpie_q;
    mstatus_rd[12:11]        = mstatus_mpp_q;
  end

  always_comb begin
    case (csr_addr_i)
      `CSR_MSTATUS: csr_rdata_o = mstatus_rd;
      `CSR_MIE:     csr_rdata_o = mie_q;
      `CSR_MIP:     csr_rdata_o = irq_if.mip;
      `CSR_MCAUSE:  csr_rdata_o = mcause_q;
      default:      csr_rdata_o = '0;  // Unimplemented reads as zero
    endcase
  end

  // Outputs to the controller
  assign irq_if.mie  = mie_q;
  assign irq_if.priv = priv_q;

  // Below machine mode interrupts are always globally enabled
  assign irq_if.m_ie = mstatus_mie_q || (priv_q != priv_machine);

endmodule

// ==== hw/irq_trap_seq.sv ====
/*
  Sends one trap per free credit to the core.
  A credit is consumed by the trap_valid_o pulse and returned by trap_credit_i.
  The core must never return more credits than it was granted.
  A request without credit waits with no time limit.
*/
`timescale 1ns/1ps
`include "irq_cfg.svh"

module irq_trap_seq import irq_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output logic      trap_valid_o,   // One-cycle trap request to the core
  output csr_data_t trap_cause_o,   // Cause for the core, held after the pulse
  input  logic      trap_credit_i,  // Credit return pulse
  irq_ctrl_if.seq   irq_if          // From controller, to CSR block
);

  trap_state_t state_q;
  trap_state_t state_d;
  credit_t     credit_q;  // Free trap credits
  credit_t     credit_d;
  csr_data_t   cause_q;   // Latched cause
  logic        take;      // Accept request this cycle

  // Interrupt cause has bit 31 set
  assign irq_if.trap_cause = {1'b1, 26'd0, irq_if.irq_id};

  // Start only from idle with a credit left
  assign take = (state_q == TRAP_IDLE) && irq_if.irq_req && (credit_q != '0);
  assign irq_if.trap_take = take;

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      TRAP_IDLE:  if (take) state_d = TRAP_ISSUE;
      TRAP_ISSUE: state_d = TRAP_IDLE;  // Single cycle pulse
      default:    state_d = TRAP_IDLE;
    endcase
  end

  assign trap_valid_o = (state_q == TRAP_ISSUE);

  // Credit counter, return and consume together cancel
  always_comb begin
    case ({trap_credit_i, trap_valid_o})
      2'b10:   credit_d = credit_q + credit_t'(1);
      2'b01:   credit_d = credit_q - credit_t'(1);
      default: credit_d = credit_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= TRAP_IDLE;
      credit_q <= credit_t'(`TRAP_CREDITS);  // Full after reset
    end else begin
      state_q  <= state_d;
      credit_q <= credit_d;
    end
  end

  // Cause payload
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cause_q <= '0;
    end else if (take) begin
      cause_q <= irq_if.trap_cause;
    end
  end

  assign trap_cause_o = cause_q;

endmodule

// ==== hw/irq_top.sv ====
/*
  Top level of the machine-mode interrupt unit.
  All ports are plain, the internal blocks talk through irq_ctrl_if.
  irq_wu_o is combinational from irq_i and mie.
*/
`timescale 1ns/1ps

module irq_top import irq_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Interrupt lines
  input  irq_vec_t  irq_i,
  // CSR access
  input  logic      csr_we_i,
  input  csr_addr_t csr_addr_i,
  input  csr_data_t csr_wdata_i,
  output csr_data_t csr_rdata_o,
  input  logic      mret_i,
  // Trap delivery
  output logic      trap_valid_o,
  output csr_data_t trap_cause_o,
  input  logic      trap_credit_i,
  // Wake-up
  output logic      irq_wu_o
);

  irq_ctrl_if u_if ();  // Internal bundle

  irq_int_controller u_ctrl (
    .clk    (clk),
    .rst_n  (rst_n),
    .irq_i  (irq_i),
    .irq_if (u_if.ctrl)
  );

  irq_csr_regs u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .mret_i      (mret_i),
    .irq_if      (u_if.csr)
  );

  irq_trap_seq u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .trap_valid_o  (trap_valid_o),
    .trap_cause_o  (trap_cause_o),
    .trap_credit_i (trap_credit_i),
    .irq_if        (u_if.seq)
  );

  assign irq_wu_o = u_if.irq_wu;

endmodule

// ==== test/irq_chk.sv ====
/*
  Trap delivery assertions, bound into irq_top.
  Credit count and MIE are probed inside the sequencer and the CSR block.
  Failed assertions are counted in fail_count.
*/
`timescale 1ns/1ps

module irq_chk import irq_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    trap_valid_i,  // DUT trap_valid_o
  input credit_t credit_i,      // Free trap credits
  input logic    mstatus_mie_i  // Global machine enable
);

  int fail_count = 0;  // Failed assertions so far

  // One cycle pulse only
  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_i |=> !trap_valid_i)
    else begin
      fail_count++;
      $error("trap_valid_o high for two cycles (failure %0d)", fail_count);
    end

  // Count is sampled before the consume
  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_i |-> credit_i != '0)
    else begin
      fail_count++;
      $error("trap sent with no credit left (failure %0d)", fail_count);
    end

  a_mie_clear: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_i |=> !mstatus_mie_i)  // Cleared by trap entry
    else begin
      fail_count++;
      $error("mstatus.MIE still set after a trap (failure %0d)", fail_count);
    end

  // First cycle out of reset
  a_reset: assert property (@(posedge clk) $rose(rst_n) |-> !trap_valid_i)
    else begin
      fail_count++;
      $error("trap_valid_o high right after reset (failure %0d)", fail_count);
    end

endmodule

bind irq_top irq_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .trap_valid_i  (trap_valid_o),
  .credit_i      (u_seq.credit_q),
  .mstatus_mie_i (u_csr.mstatus_mie_q)
);

// ==== test/irq_tb.sv ====
/*
  Testbench for irq_top, stepped by test/irq_golden.txt, run from the project root.
  Steps start on a rising edge, outputs are sampled on the falling edge.
  A monitor queues every trap, so a T step may find its trap already waiting.
*/
`timescale 1ns/1ps

module irq_tb import irq_pkg::*; ;

  localparam int wait_limit = 100;  // Cycles before a trap wait gives up

  logic      clk           = 1'b0;
  logic      rst_n         = 1'b0;
  logic      csr_we_i      = 1'b0;
  logic      mret_i        = 1'b0;
  logic      trap_credit_i = 1'b0;
  irq_vec_t  irq_i         = '0;
  csr_addr_t csr_addr_i    = '0;
  csr_data_t csr_wdata_i   = '0;
  logic      trap_valid_o;            // DUT outputs
  logic      irq_wu_o;
  csr_data_t csr_rdata_o;
  csr_data_t trap_cause_o;
  int        errors   = 0;            // Value mismatches
  int        timeouts = 0;
  csr_data_t traps[$];                // Causes seen, oldest first

  irq_top u_dut (.*);

  initial begin
    forever #50 clk = ~clk;  // 100 ns period
  end

  // Trap monitor, mid-cycle
  always @(negedge clk) begin
    if (rst_n && trap_valid_o) traps.push_back(trap_cause_o);
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // Golden file steps
  //////////////////////////////
  initial begin
    int          fd;
    int          n;
    int          lnum;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    string       line;
    string       name;
    n    = $urandom(32'hcdd);  // Seed for the idle gaps
    lnum = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("test/irq_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/irq_golden.txt, no steps were run");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      op   = "#";  // Blank and comment lines drive nothing
      line = "";
      n    = $fgets(line, fd);
      n    = $sscanf(line, "%c %h %h", op, a, b);
      lnum++;
      name = $sformatf("line %0d op %c", lnum, op);
      repeat ($urandom % 3) @(posedge clk);  // Idle gap
      @(posedge clk);
      csr_we_i      <= (op == "W");
      mret_i        <= (op == "M");
      trap_credit_i <= (op == "C");  // Credit return pulse
      if (op == "W" || op == "R") csr_addr_i <= a[11:0];
      if (op == "W") csr_wdata_i <= b;
      if (op == "I") irq_i <= a;
      @(negedge clk);
      if (op == "R") check(name, b, csr_rdata_o);  // Read is combinational
      @(posedge clk);
      csr_we_i      <= 1'b0;
      mret_i        <= 1'b0;
      trap_credit_i <= 1'b0;
      if (op == "T") begin
        n = 0;
        while (traps.size() == 0 && n < wait_limit) begin
          @(posedge clk);
          n++;
        end
        if (traps.size() == 0) begin
          $display("Timeout on %s: no trap arrived within %0d cycles", name, wait_limit);
          timeouts++;
        end else begin
          check(name, a, traps.pop_front());
        end
      end
      if (op == "N") begin
        repeat (a) @(posedge clk);
        check({name, " trap count"}, 0, traps.size());  // Nothing may arrive
        @(negedge clk);
        check({name, " wake-up"}, b, irq_wu_o);
      end
    end
    if (fd != 0) $fclose(fd);
    check("end of run trap count", 0, traps.size());
    $display("Done: %0d mismatches, %0d timeouts, %0d assertion failures",
             errors, timeouts, u_dut.u_chk.fail_count);
    if (errors == 0 && timeouts == 0 && u_dut.u_chk.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== test/irq_golden.txt ====
# op a b: W addr data, R addr expect, I lines, M mret, C credit, T cause, N cycles wake-up
W 300 8
I ffffffff
R 344 ffff0888
N 8 0
W 304 100888
T 80000014
R 300 1880
R 342 80000014
W 304 888
M
T 8000000b
I 88
M
N 10 1
C
T 80000003
C
I 80
M
T 80000007
C
I 0
M
R 300 88
W 300 0
I 800
N 8 1

// ==== compile.f ====
+incdir+hw
hw/irq_pkg.sv
hw/irq_ctrl_if.sv
hw/irq_int_controller.sv
hw/irq_csr_regs.sv
hw/irq_trap_seq.sv
hw/irq_top.sv
test/irq_chk.sv
test/irq_tb.sv
